/* hw/fetch_consts.svh */
// Shared widths and limits of the instruction prefetcher, included by packages and RTL
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Bus and CPU widths
`define FETCH_ADDR_W          32
`define FETCH_BUS_W           64
`define FETCH_INSN_W          32
`define FETCH_INSNS_PER_WORD  2
// Byte offset bits within one bus word
`define FETCH_WORD_LSB        3

// Words requested but not yet consumed
`define FETCH_LIMIT           8
// FIFO index width, log2 of FETCH_LIMIT
`define FETCH_LGFIFO          3
// In-flight read counter width
`define FETCH_LGDEPTH         5

// Unprivileged, secure, instruction access
`define FETCH_ARPROT          3'b100

`endif

/* hw/axil_pkg.sv */
// Bus-side types of the AXI-lite read channels, shared by the prefetcher and its bus model
`include "fetch_consts.svh"

package axil_pkg;

	//////////////////////////////
	// Read address channel
	//////////////////////////////

	typedef struct packed {
		logic [`FETCH_ADDR_W-1:0] addr;
		// Protection bits, constant per fetch
		logic [2:0]               prot;
	} ar_req_t;

	//////////////////////////////
	// Read data channel
	//////////////////////////////

	typedef struct packed {
		// Raw bus word, lanes in bus byte order
		logic [`FETCH_BUS_W-1:0]  data;
		// OKAY 00, SLVERR 10, DECERR 11
		logic [1:0]               resp;
	} r_resp_t;

endpackage

/* hw/fetch_pkg.sv */
// CPU-side and internal types of the prefetcher: output bundle, FIFO entry, FSM states
`include "fetch_consts.svh"

package fetch_pkg;

	// Instruction handed to the CPU
	typedef struct packed {
		logic [`FETCH_INSN_W-1:0] insn;
		logic [`FETCH_ADDR_W-1:0] pc;
		logic                     illegal;
	} fetch_out_t;

	// One buffered bus word, already swapped
	typedef struct packed {
		logic [`FETCH_BUS_W-1:0]  data;
		logic                     err;
	} fifo_word_t;

	// Request controller states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		FETCH = 2'd1,
		HALT  = 2'd2
	} ctrl_state_t;

endpackage

/* hw/fetch_ctrl.sv */
// Read request FSM of the prefetcher: decides when to issue and which address to fetch
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_ctrl (
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	input  logic                     i_new_pc,
	input  logic [`FETCH_ADDR_W-1:0] i_pc,
	input  logic                     i_arready,
	input  logic                     i_throttle,
	input  logic                     i_halt_req,
	output logic                     o_arvalid,
	output axil_pkg::ar_req_t        o_ar,
	output fetch_pkg::ctrl_state_t   o_state,
	output logic                     o_pending_pc
);
	import fetch_pkg::*;

	ctrl_state_t              state;
	logic [`FETCH_ADDR_W-1:0] req_addr;
	logic [`FETCH_ADDR_W-1:0] pending_addr;
	logic                     ar_open;
	logic                     issue;

	// Channel free to take a new request
	assign ar_open = !o_arvalid || i_arready;
	// Redirects always issue; otherwise only once started and not halting
	assign issue = !i_throttle
		&& (i_new_pc || o_pending_pc || (state != IDLE && !i_halt_req));

	//////////////////////////////
	// State
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			state <= IDLE;
		else if (i_new_pc)
			state <= FETCH;
		else if (state == FETCH && i_halt_req)
			state <= HALT;
	end

	//////////////////////////////
	// Request valid
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
			o_arvalid <= 1'b0;
		else if (ar_open)
			o_arvalid <= issue;
	end

	// Redirect that arrived while a request was stalled
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || ar_open)
			o_pending_pc <= 1'b0;
		else if (i_new_pc)
			o_pending_pc <= 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_addr <= i_pc;
	end

	//////////////////////////////
	// Request address
	//////////////////////////////

	// Holds the next address to ask for once the channel opens
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_open)
		begin
			if (i_new_pc)
				req_addr <= i_pc;
			else if (o_pending_pc)
				req_addr <= pending_addr;
			else if (o_arvalid)
			begin
				// Next bus word, always aligned
				req_addr[`FETCH_ADDR_W-1:`FETCH_WORD_LSB]
					<= req_addr[`FETCH_ADDR_W-1:`FETCH_WORD_LSB] + 1'b1;
				req_addr[`FETCH_WORD_LSB-1:0] <= '0;
			end
		end
	end

	assign o_ar    = '{addr: req_addr, prot: `FETCH_ARPROT};
	assign o_state = state;

endmodule

/* hw/fetch_counters.sv */
// Bookkeeping of the prefetcher: in-flight reads, buffered words, flush count, throttle
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_counters (
	input  logic                   S_AXI_ACLK,
	input  logic                   fifo_reset,
	input  logic                   i_new_pc,
	input  logic                   i_arvalid,
	input  logic                   i_arready,
	input  logic                   i_rvalid,
	input  logic                   i_pop,
	input  logic                   i_held_words,
	input  logic                   i_pending_pc,
	input  fetch_pkg::ctrl_state_t i_state,
	output logic                   o_throttle,
	output logic                   o_flushing
);
	import fetch_pkg::*;

	localparam int unsigned CW = `FETCH_LGDEPTH + 1;
	localparam int unsigned FW = `FETCH_LGFIFO + 1;

	logic          ar_xfer;
	logic [CW-1:0] outstanding;
	logic [CW-1:0] next_outstanding;
	logic [CW-1:0] flush_count;
	logic [CW-1:0] new_flush_count;
	logic          full_bus;
	logic [FW-1:0] fill;
	logic [FW:0]   demand;

	assign ar_xfer = i_arvalid && i_arready;

	//////////////////////////////
	// In-flight reads
	//////////////////////////////

	always_comb
	begin
		next_outstanding = outstanding + CW'(ar_xfer) - CW'(i_rvalid);
	end

	// Survives a redirect, the bus still owes these
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			outstanding <= '0;
			full_bus    <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			full_bus    <= next_outstanding >= CW'((1 << `FETCH_LGDEPTH) - 1);
		end
	end

	//////////////////////////////
	// Words requested, not popped
	//////////////////////////////

	// Stale stalled request is not counted
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_new_pc)
			fill <= '0;
		else
			fill <= fill + FW'(ar_xfer && !i_pending_pc) - FW'(i_pop);
	end

	//////////////////////////////
	// Flush
	//////////////////////////////

	// Owed responses, plus the open request, minus one landing now
	assign new_flush_count = outstanding + CW'(i_arvalid) - CW'(i_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			flush_count <= '0;
			o_flushing  <= 1'b0;
		end
		else if (i_new_pc)
		begin
			flush_count <= new_flush_count;
			o_flushing  <= new_flush_count != '0;
		end
		else if (i_rvalid && o_flushing)
		begin
			flush_count <= flush_count - 1'b1;
			o_flushing  <= flush_count > CW'(1);
		end
	end

	// Buffered, about to transfer, and held at the output
	assign demand = (FW + 1)'(fill) + (FW + 1)'(i_arvalid) + (FW + 1)'(i_held_words);

	// A halted stream stays throttled until redirected
	assign o_throttle = (demand >= (FW + 1)'(`FETCH_LIMIT))
		|| full_bus
		|| (i_state == HALT && !i_new_pc);

endmodule

/* hw/word_fifo.sv */
// Synchronous FIFO of swapped bus words between the read channel and the unpacker
`timescale 1ns/1ps
`include "fetch_consts.svh"

module word_fifo (
	input  logic                  S_AXI_ACLK,
	input  logic                  fifo_reset,
	input  logic                  i_clear,
	input  logic                  i_wr,
	input  fetch_pkg::fifo_word_t i_data,
	input  logic                  i_rd,
	output fetch_pkg::fifo_word_t o_data,
	output logic                  o_empty
);
	import fetch_pkg::*;

	fifo_word_t              mem [0:`FETCH_LIMIT-1];
	// Extra top bit tells full from empty
	logic [`FETCH_LGFIFO:0]  wr_ptr;
	logic [`FETCH_LGFIFO:0]  rd_ptr;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[`FETCH_LGFIFO-1:0]] <= i_data;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_rd && !o_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Head word shows without a read cycle
	assign o_data  = mem[rd_ptr[`FETCH_LGFIFO-1:0]];
	assign o_empty = wr_ptr == rd_ptr;

endmodule

/* hw/insn_unpack.sv */
// Output stage of the prefetcher: splits bus words into instructions for the CPU handshake
`timescale 1ns/1ps
`include "fetch_consts.svh"

module insn_unpack (
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	input  logic                     i_new_pc,
	input  logic [`FETCH_ADDR_W-1:0] i_pc,
	input  fetch_pkg::fifo_word_t    i_word,
	input  logic                     i_empty,
	input  logic                     i_ready,
	output logic                     o_rd,
	output logic                     o_valid,
	output fetch_pkg::fetch_out_t    o_fetch,
	output logic                     o_held_words
);
	logic                     want_word;
	logic                     shift;
	logic [1:0]               out_fill;
	logic [`FETCH_BUS_W-1:0]  out_data;
	logic [`FETCH_ADDR_W-1:0] out_pc;
	logic                     illegal;

	// Empty, or last instruction leaving; frozen once illegal
	assign want_word = !illegal && (!o_valid || (i_ready && out_fill <= 2'd1));
	assign o_rd      = want_word && !i_empty;
	// Only a word entered cold can start mid-word
	assign shift     = !o_valid && out_pc[2];

	//////////////////////////////
	// Output fill
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_new_pc)
			out_fill <= '0;
		else if (want_word)
			out_fill <= i_empty ? 2'd0
				: 2'(`FETCH_INSNS_PER_WORD) - 2'(shift);
		else if (i_ready && out_fill != '0 && !illegal)
			out_fill <= out_fill - 1'b1;
	end

	assign o_valid = out_fill != '0;

	// Upper lane moves down as each instruction goes
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_rd)
			out_data <= shift ? (i_word.data >> `FETCH_INSN_W) : i_word.data;
		else if (o_valid && i_ready && !illegal)
			out_data <= out_data >> `FETCH_INSN_W;
	end

	//////////////////////////////
	// PC and error
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			out_pc <= i_pc;
		else if (o_valid && i_ready && !illegal)
		begin
			out_pc[`FETCH_ADDR_W-1:2] <= out_pc[`FETCH_ADDR_W-1:2] + 1'b1;
			out_pc[1:0] <= 2'b00;
		end
	end

	// Sticky until redirect
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset || i_new_pc)
			illegal <= 1'b0;
		else if (o_rd && !illegal)
			illegal <= i_word.err;
	end

	// Word still occupying the output next cycle
	assign o_held_words = o_valid && (!i_ready || out_fill > 2'd1 || illegal);

	assign o_fetch = '{
		insn:    out_data[`FETCH_INSN_W-1:0],
		pc:      out_pc,
		illegal: illegal
	};

endmodule

/* hw/axil_fetch.sv */
// Top of the AXI-lite instruction prefetcher, instantiated between CPU and read-only bus
`timescale 1ns/1ps
`include "fetch_consts.svh"

module axil_fetch (
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	input  logic                     i_new_pc,
	input  logic [`FETCH_ADDR_W-1:0] i_pc,
	input  logic                     i_ready,
	input  logic                     i_arready,
	input  logic                     i_rvalid,
	input  axil_pkg::r_resp_t        i_r,
	output logic                     o_valid,
	output fetch_pkg::fetch_out_t    o_fetch,
	output logic                     o_arvalid,
	output axil_pkg::ar_req_t        o_ar,
	output logic                     o_rready
);
	import fetch_pkg::*;

	ctrl_state_t             state;
	logic                    throttle;
	logic                    flushing;
	logic                    pending_pc;
	logic                    held_words;
	logic                    fifo_wr;
	logic                    fifo_rd;
	logic                    fifo_empty;
	fifo_word_t              fifo_in;
	fifo_word_t              fifo_out;
	logic [`FETCH_BUS_W-1:0] swapped;

	// Big-endian instructions, reverse bytes in each 32-bit lane
	for (genvar lane = 0; lane < `FETCH_BUS_W / 32; lane++)
	begin : g_lane
		for (genvar b = 0; b < 4; b++)
		begin : g_byte
			assign swapped[lane * 32 + (3 - b) * 8 +: 8] = i_r.data[lane * 32 + b * 8 +: 8];
		end
	end

	assign o_rready = 1'b1;
	// Stale responses are dropped while flushing
	assign fifo_wr  = i_rvalid && !flushing;
	assign fifo_in  = '{data: swapped, err: i_r.resp[1]};

	fetch_ctrl fetch_ctrl_inst (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.fifo_reset   (fifo_reset),
		.i_new_pc     (i_new_pc),
		.i_pc         (i_pc),
		.i_arready    (i_arready),
		.i_throttle   (throttle),
		.i_halt_req   (o_fetch.illegal),
		.o_arvalid    (o_arvalid),
		.o_ar         (o_ar),
		.o_state      (state),
		.o_pending_pc (pending_pc)
	);

	fetch_counters fetch_counters_inst (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.fifo_reset   (fifo_reset),
		.i_new_pc     (i_new_pc),
		.i_arvalid    (o_arvalid),
		.i_arready    (i_arready),
		.i_rvalid     (i_rvalid),
		.i_pop        (fifo_rd),
		.i_held_words (held_words),
		.i_pending_pc (pending_pc),
		.i_state      (state),
		.o_throttle   (throttle),
		.o_flushing   (flushing)
	);

	word_fifo word_fifo_inst (
		.S_AXI_ACLK (S_AXI_ACLK),
		.fifo_reset (fifo_reset),
		.i_clear    (i_new_pc),
		.i_wr       (fifo_wr),
		.i_data     (fifo_in),
		.i_rd       (fifo_rd),
		.o_data     (fifo_out),
		.o_empty    (fifo_empty)
	);

	insn_unpack insn_unpack_inst (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.fifo_reset   (fifo_reset),
		.i_new_pc     (i_new_pc),
		.i_pc         (i_pc),
		.i_word       (fifo_out),
		.i_empty      (fifo_empty),
		.i_ready      (i_ready),
		.o_rd         (fifo_rd),
		.o_valid      (o_valid),
		.o_fetch      (o_fetch),
		.o_held_words (held_words)
	);

endmodule

/* testbench/axil_mem_model.sv */
// AXI-lite read slave for the prefetcher testbench, with random delays and one error word
`timescale 1ns/1ps
`include "fetch_consts.svh"

module axil_mem_model (
	input  logic                     S_AXI_ACLK,
	input  logic                     fifo_reset,
	input  logic                     i_arvalid,
	input  axil_pkg::ar_req_t        i_ar,
	input  logic                     i_err_en,
	input  logic [`FETCH_ADDR_W-1:0] i_err_addr,
	output logic                     o_arready,
	output logic                     o_rvalid,
	output axil_pkg::r_resp_t        o_r,
	output int                       o_inflight
);
	import axil_pkg::*;

	localparam logic [31:0] INSN_KEY = 32'h5a5a0000;

	logic [31:0] addr_q [$];
	integer      seed;

	// Bus byte order, reversed per lane
	function automatic logic [31:0] byte_rev(input logic [31:0] x);
		return {x[7:0], x[15:8], x[23:16], x[31:24]};
	endfunction

	// Lane n holds the instruction at word address + 4n
	function automatic r_resp_t read_word(input logic [31:0] addr);
		r_resp_t     beat;
		logic [31:0] base;
		base      = {addr[31:`FETCH_WORD_LSB], 3'b000};
		beat.data = {byte_rev((base + 32'd4) ^ INSN_KEY), byte_rev(base ^ INSN_KEY)};
		beat.resp = (i_err_en && base[31:3] == i_err_addr[31:3]) ? 2'b10 : 2'b00;
		return beat;
	endfunction

	initial
	begin
		seed       = 32'hfa3b1769;
		o_arready  = 1'b0;
		o_rvalid   = 1'b0;
		o_r        = '0;
		o_inflight = 0;
	end

	//////////////////////////////
	// Address and data channels
	//////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			addr_q.delete();
			o_arready  <= 1'b0;
			o_rvalid   <= 1'b0;
			o_inflight <= 0;
		end
		else
		begin
			// Master sees a read in flight until its beat shows
			o_inflight <= o_inflight + int'(i_arvalid && o_arready) - int'(o_rvalid);
			if (i_arvalid && o_arready)
				addr_q.push_back(i_ar.addr);
			// Ready three cycles in four
			o_arready <= ($unsigned($random(seed)) % 4) != 0;
			o_rvalid  <= 1'b0;
			if (addr_q.size() != 0 && ($unsigned($random(seed)) % 2) == 0)
			begin
				o_rvalid <= 1'b1;
				o_r      <= read_word(addr_q.pop_front());
			end
		end
	end

endmodule

/* testbench/tb_axil_fetch.sv */
// Testbench of the prefetcher: runs a table of fetch streams against a random-delay bus model
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_axil_fetch;
	import axil_pkg::*;
	import fetch_pkg::*;

	localparam int          NROWS    = 5;
	localparam logic [31:0] INSN_KEY = 32'h5a5a0000;

	// Start PC, max count, error word, redirect point and target, CPU ready percent
	typedef struct packed {
		logic [31:0] pc;
		logic [15:0] count;
		logic        err_en;
		logic [31:0] err_addr;
		logic [7:0]  redir_at;
		logic [31:0] redir_pc;
		logic [7:0]  ready_pct;
	} row_t;

	row_t        stim [0:NROWS-1];
	logic        clk;
	logic        fifo_reset;
	logic        new_pc;
	logic [31:0] pc;
	logic        ready;
	logic        arready;
	logic        rvalid;
	r_resp_t     r;
	logic        valid;
	fetch_out_t  fetch;
	logic        arvalid;
	ar_req_t     ar;
	logic        rready;
	logic        err_en;
	logic [31:0] err_addr;
	int          inflight;
	int          ar_xfers;
	logic        track_en;
	integer      seed;
	int          budget;

	axil_fetch axil_fetch_inst (
		.S_AXI_ACLK (clk),
		.fifo_reset (fifo_reset),
		.i_new_pc   (new_pc),
		.i_pc       (pc),
		.i_ready    (ready),
		.i_arready  (arready),
		.i_rvalid   (rvalid),
		.i_r        (r),
		.o_valid    (valid),
		.o_fetch    (fetch),
		.o_arvalid  (arvalid),
		.o_ar       (ar),
		.o_rready   (rready)
	);

	axil_mem_model axil_mem_model_inst (
		.S_AXI_ACLK (clk),
		.fifo_reset (fifo_reset),
		.i_arvalid  (arvalid),
		.i_ar       (ar),
		.i_err_en   (err_en),
		.i_err_addr (err_addr),
		.o_arready  (arready),
		.o_rvalid   (rvalid),
		.o_r        (r),
		.o_inflight (inflight)
	);

	always #5 clk = ~clk;

	//////////////////////////////
	// Reporting
	//////////////////////////////

	task automatic fail_stop();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			fail_stop();
		end
	endtask

	function automatic logic ready_draw(input logic [7:0] pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	// AR transfers and the in-flight bound, sampled mid-cycle
	always @(negedge clk)
	begin
		if (!fifo_reset && arvalid && arready)
			ar_xfers <= ar_xfers + 1;
		if (track_en && inflight > `FETCH_LIMIT)
		begin
			$display("more reads in flight than the fetch limit allows: %0d", inflight);
			fail_stop();
		end
	end

	//////////////////////////////
	// One table row
	//////////////////////////////

	// Stop the CPU and let the bus go quiet
	task automatic drain();
		@(posedge clk);
		ready <= 1'b0;
		do
			@(negedge clk);
		while (inflight != 0);
		@(posedge clk);
	endtask

	task automatic run_row(input row_t row);
		logic [31:0] exp_pc;
		int          accepted;
		int          xfers;
		logic        redirected;
		logic        hold;
		logic        done;
		logic        illegal_seen;
		fetch_out_t  held;
		exp_pc       = row.pc;
		accepted     = 0;
		redirected   = row.redir_at == 0;
		hold         = 1'b0;
		done         = 1'b0;
		illegal_seen = 1'b0;
		err_addr <= row.err_addr;
		err_en   <= row.err_en;
		track_en <= row.redir_at == 0;
		new_pc   <= 1'b1;
		pc       <= row.pc;
		ready    <= ready_draw(row.ready_pct);
		while (!done)
		begin
			@(negedge clk);
			// Unprivileged secure instruction access on every request
			if (arvalid)
				check("o_ar.prot", ar.prot, 3'b100);
			// Output still shows the old stream while the new PC is taken
			if (new_pc)
				hold = 1'b0;
			else
			begin
				// Output held under back-pressure
				if (hold)
				begin
					check("o_fetch.pc", fetch.pc, held.pc);
					check("o_fetch.insn", fetch.insn, held.insn);
					check("o_fetch.illegal", fetch.illegal, held.illegal);
				end
				if (valid && row.err_en && exp_pc[31:3] == row.err_addr[31:3])
				begin
					check("o_fetch.illegal", fetch.illegal, 1'b1);
					check("o_fetch.pc", fetch.pc, exp_pc);
					illegal_seen = 1'b1;
					done         = 1'b1;
				end
				else if (valid)
				begin
					check("o_fetch.illegal", fetch.illegal, 1'b0);
					if (ready)
					begin
						check("o_fetch.pc", fetch.pc, exp_pc);
						check("o_fetch.insn", fetch.insn, exp_pc ^ INSN_KEY);
						exp_pc   = exp_pc + 32'd4;
						accepted = accepted + 1;
					end
				end
				hold = valid && !ready;
				held = fetch;
			end
			if (redirected && accepted == int'(row.count))
				done = 1'b1;
			@(posedge clk);
			new_pc <= 1'b0;
			ready  <= ready_draw(row.ready_pct);
			// Mid-stream jump to a new sequence
			if (!redirected && accepted == int'(row.redir_at))
			begin
				new_pc     <= 1'b1;
				pc         <= row.redir_pc;
				exp_pc     = row.redir_pc;
				accepted   = 0;
				redirected = 1'b1;
			end
		end
		if (row.err_en)
		begin
			if (!illegal_seen)
			begin
				$display("stream ended before reaching the error address");
				fail_stop();
			end
			// Frozen output until the next redirect
			repeat (30)
			begin
				@(negedge clk);
				check("o_valid", valid, 1'b1);
				check("o_fetch.illegal", fetch.illegal, 1'b1);
				check("o_fetch.pc", fetch.pc, held.pc);
				@(posedge clk);
				ready <= ready_draw(row.ready_pct);
			end
			drain();
			xfers = ar_xfers;
			repeat (20) @(posedge clk);
			check("ar_xfers", ar_xfers, xfers);
		end
		drain();
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		stim[0]    = '{32'h0000_1000, 16'd40, 1'b0, 32'h0, 8'd0, 32'h0, 8'd100};
		stim[1]    = '{32'h0000_2004, 16'd30, 1'b0, 32'h0, 8'd0, 32'h0, 8'd60};
		stim[2]    = '{32'h0000_3000, 16'd20, 1'b0, 32'h0, 8'd7, 32'h0000_4104, 8'd80};
		stim[3]    = '{32'h0000_5000, 16'd100, 1'b1, 32'h0000_5018, 8'd0, 32'h0, 8'd70};
		stim[4]    = '{32'h0000_600c, 16'd25, 1'b0, 32'h0, 8'd0, 32'h0, 8'd30};
		seed       = 32'hfa3b1769;
		clk        = 1'b0;
		fifo_reset = 1'b1;
		new_pc     = 1'b0;
		pc         = '0;
		ready      = 1'b0;
		err_en     = 1'b0;
		err_addr   = '0;
		ar_xfers   = 0;
		track_en   = 1'b0;
		repeat (16) @(posedge clk);
		fifo_reset <= 1'b0;
		// Quiet until the first new PC
		repeat (20)
		begin
			@(negedge clk);
			check("o_valid", valid, 1'b0);
			check("o_arvalid", arvalid, 1'b0);
			check("o_rready", rready, 1'b1);
		end
		@(posedge clk);
		for (int i = 0; i < NROWS; i++)
			run_row(stim[i]);
		$display("*** TEST PASSED ***");
		$finish;
	end

	// Budget of 40 cycles per instruction plus per-row overhead
	initial
	begin
		#1;
		budget = 500;
		for (int i = 0; i < NROWS; i++)
			budget = budget + 40 * (int'(stim[i].count) + int'(stim[i].redir_at)) + 300;
		repeat (budget) @(posedge clk);
		$display("timeout, the stream did not finish in %0d cycles", budget);
		fail_stop();
	end

endmodule

/* axil_fetch.f */
+incdir+hw
hw/axil_pkg.sv
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/fetch_counters.sv
hw/word_fifo.sv
hw/insn_unpack.sv
hw/axil_fetch.sv
testbench/axil_mem_model.sv
testbench/tb_axil_fetch.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_axil_fetch
FILELIST  := axil_fetch.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv hw/*.svh testbench/*.sv) $(FILELIST)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf $(OBJDIR)
